// ==== uartPkg.sv ====
package uartPkg;

    // Legal range of the frame format.
    localparam int MinDataBits = 5;
    localparam int MaxDataBits = 9;
    localparam int MaxStopBits = 2;

    // One received character as it is queued for the host.
    typedef struct packed {
        logic [MaxDataBits-1:0] data;   // Zero-extended for narrow formats.
        logic                   isBreak;
        logic                   parityErr;
        logic                   framingErr;
    } rxFrame;

    typedef enum logic [2:0] {
        Idle,
        StartCheck,
        Receive,
        Check,
        BreakWait
    } rxState;

endpackage

// ==== rxControl.sv ====
`timescale 1ns/1ns

module rxControl import uartPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic lineSync,
    input  logic sampleTick,
    input  logic lastBit,
    input  logic frameBreak,
    output logic timerStart,
    output logic timerRun,
    output logic shiftEn,
    output logic checkNow
);

    rxState state;
    rxState nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            Idle: begin
                if (!lineSync) begin
                    nextState = StartCheck;   // Falling edge of the start bit.
                end
            end
            StartCheck: begin
                if (sampleTick) begin
                    // A start bit that is high again by mid-bit was a glitch.
                    nextState = lineSync ? Idle : Receive;
                end
            end
            Receive: begin
                if (sampleTick && lastBit) begin
                    nextState = Check;
                end
            end
            Check: begin
                nextState = frameBreak ? BreakWait : Idle;
            end
            BreakWait: begin
                if (lineSync) begin
                    nextState = Idle;         // One break gives one record.
                end
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    assign timerStart = (state == Idle) && !lineSync;
    assign timerRun   = (state == StartCheck) || (state == Receive);
    assign shiftEn    = sampleTick && (state == Receive);
    assign checkNow   = (state == Check);

    // The first data sample is a full bit after the start sample, so every
    // shift falls well inside Receive and never on its entry cycle.
    assert property (@(posedge clk) disable iff (rst)
        shiftEn |-> $past(state) == Receive);

endmodule

// ==== bitTimer.sv ====
`timescale 1ns/1ns

module bitTimer #(
    parameter int ClockDivider = 8,
    parameter int TotalBits    = 11
) (
    input  logic clk,
    input  logic rst,
    input  logic timerStart,
    input  logic timerRun,
    output logic sampleTick,
    output logic lastBit
);

    localparam int CountWidth = $clog2(ClockDivider);
    localparam int IndexWidth = $clog2(TotalBits);
    localparam logic [CountWidth-1:0] HalfLoad = CountWidth'(ClockDivider / 2 - 1);
    localparam logic [CountWidth-1:0] FullLoad = CountWidth'(ClockDivider - 1);

    logic [CountWidth-1:0] count;
    logic [IndexWidth-1:0] bitIndex;

    // Counts down; parked at a full period while the timer is idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= FullLoad;
        end else if (timerStart) begin
            count <= HalfLoad;              // First tick lands mid start bit.
        end else if (!timerRun || sampleTick) begin
            count <= FullLoad;
        end else begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bitIndex <= '0;
        end else if (timerStart) begin
            bitIndex <= '0;
        end else if (sampleTick) begin
            bitIndex <= bitIndex + 1'b1;
        end
    end

    assign sampleTick = (count == '0);
    assign lastBit    = (bitIndex == IndexWidth'(TotalBits - 1));

    // The tick is not gated here, so this relies on the FSM dropping timerRun.
    assert property (@(posedge clk) disable iff (rst) sampleTick |-> timerRun);

endmodule

// ==== rxShiftReg.sv ====
`timescale 1ns/1ns

module rxShiftReg #(
    parameter int Width = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             shiftEn,
    input  logic             lineSync,
    output logic [Width-1:0] frameBits
);

    // Bits enter at the top, so after a full frame the first data bit sits at bit 0.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frameBits <= '1;
        end else if (shiftEn) begin
            frameBits <= {lineSync, frameBits[Width-1:1]};
        end
    end

endmodule

// ==== frameCheck.sv ====
`timescale 1ns/1ns

module frameCheck import uartPkg::*; #(
    parameter int DataBits   = 8,
    parameter int StopBits   = 1,
    parameter int ParityBits = 0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [DataBits+ParityBits+StopBits-1:0] frameBits,
    input  logic                                    checkNow,
    output logic                                    frameBreak,
    output rxFrame                                  newFrame,
    output logic                                    frameWrite
);

    localparam int Width = DataBits + ParityBits + StopBits;

    logic [DataBits-1:0] dataField;
    logic [StopBits-1:0] stopField;
    logic                parityBad;
    rxFrame              record;

    assign dataField  = frameBits[DataBits-1:0];
    assign stopField  = frameBits[Width-1 -: StopBits];
    assign frameBreak = (frameBits == '0);
    // Even parity; the index is a stop bit when parity is off, but unused then.
    assign parityBad  = (ParityBits == 1) && ((^dataField) != frameBits[DataBits]);

    always_comb begin
        record.data       = MaxDataBits'(dataField);
        record.isBreak    = frameBreak;
        record.parityErr  = !frameBreak && parityBad;
        record.framingErr = !frameBreak && !(&stopField);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frameWrite <= 1'b0;
        end else begin
            frameWrite <= checkNow;
        end
    end

    always_ff @(posedge clk) begin
        if (checkNow) begin
            newFrame <= record;
        end
    end

endmodule

// ==== rxFifo.sv ====
`timescale 1ns/1ns

module rxFifo import uartPkg::*; #(
    parameter int Depth = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   frameWrite,
    input  rxFrame newFrame,
    input  logic   pop,
    output rxFrame frameOut,
    output logic   frameValid,
    output logic   overflow
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);
    localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

    rxFrame                mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  full;
    logic                  doWrite;
    logic                  doRead;

    assign full       = (count == CountWidth'(Depth));
    assign frameValid = (count != '0);
    assign doWrite    = frameWrite && !full;   // A full queue drops the record.
    assign doRead     = pop && frameValid;
    assign frameOut   = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= newFrame;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (frameWrite && full) begin
                overflow <= 1'b1;                  // Sticky until reset.
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= CountWidth'(Depth));

endmodule

// ==== uartRx.sv ====
`timescale 1ns/1ns

module uartRx import uartPkg::*; #(
    parameter int ClockDivider = 8,
    parameter int DataBits     = 8,
    parameter int StopBits     = 1,
    parameter int ParityBits   = 0,
    parameter int FifoDepth    = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rxLine,
    input  logic   pop,
    output rxFrame frameOut,
    output logic   frameValid,
    output logic   overflow
);

    localparam int FrameWidth = DataBits + ParityBits + StopBits;
    localparam int TotalBits  = 1 + FrameWidth;          // Start bit included.

    logic                  lineMeta;
    logic                  lineSync;
    logic                  timerStart;
    logic                  timerRun;
    logic                  sampleTick;
    logic                  lastBit;
    logic                  shiftEn;
    logic                  checkNow;
    logic                  frameBreak;
    logic                  frameWrite;
    logic [FrameWidth-1:0] frameBits;
    rxFrame                newFrame;

    initial begin
        if (ClockDivider < 2)
            $error("ClockDivider must be at least 2");
        if (DataBits < MinDataBits || DataBits > MaxDataBits)
            $error("DataBits must be in [%0d,%0d]", MinDataBits, MaxDataBits);
        if (StopBits < 1 || StopBits > MaxStopBits)
            $error("StopBits must be 1 or %0d", MaxStopBits);
        if (ParityBits < 0 || ParityBits > 1)
            $error("ParityBits must be 0 or 1");
        if (FifoDepth < 1)
            $error("FifoDepth must be at least 1");
    end

    // Two-flop synchronizer, idle level is high.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineMeta <= 1'b1;
            lineSync <= 1'b1;
        end else begin
            lineMeta <= rxLine;
            lineSync <= lineMeta;
        end
    end

    rxControl iControl (
        .clk(clk), .rst(rst), .lineSync(lineSync), .sampleTick(sampleTick),
        .lastBit(lastBit), .frameBreak(frameBreak), .timerStart(timerStart),
        .timerRun(timerRun), .shiftEn(shiftEn), .checkNow(checkNow)
    );

    bitTimer #(.ClockDivider(ClockDivider), .TotalBits(TotalBits)) iTimer (
        .clk(clk), .rst(rst), .timerStart(timerStart), .timerRun(timerRun),
        .sampleTick(sampleTick), .lastBit(lastBit)
    );

    rxShiftReg #(.Width(FrameWidth)) iShift (
        .clk(clk), .rst(rst), .shiftEn(shiftEn), .lineSync(lineSync),
        .frameBits(frameBits)
    );

    frameCheck #(.DataBits(DataBits), .StopBits(StopBits), .ParityBits(ParityBits)) iCheck (
        .clk(clk), .rst(rst), .frameBits(frameBits), .checkNow(checkNow),
        .frameBreak(frameBreak), .newFrame(newFrame), .frameWrite(frameWrite)
    );

    rxFifo #(.Depth(FifoDepth)) iFifo (
        .clk(clk), .rst(rst), .frameWrite(frameWrite), .newFrame(newFrame), .pop(pop),
        .frameOut(frameOut), .frameValid(frameValid), .overflow(overflow)
    );

endmodule

// ==== tbUartRx.sv ====
`timescale 1ns/1ns

module tbUartRx import uartPkg::*; ();

    localparam int BitCycles = 8;
    localparam int FrameBits = 11;

    logic   clk;
    logic   rst;
    logic   rxLine;
    logic   pop;
    rxFrame frameOut;
    logic   frameValid;
    logic   overflow;

    logic [31:0] lfsr = 32'hf14f;
    rxFrame      modelQ[$];
    int          checks;
    int          errors;
    int          testChecks;
    int          testErrors;

    uartRx #(
        .ClockDivider(BitCycles), .DataBits(8), .StopBits(1), .ParityBits(1), .FifoDepth(4)
    ) i_dut (
        .clk(clk), .rst(rst), .rxLine(rxLine), .pop(pop),
        .frameOut(frameOut), .frameValid(frameValid), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1.
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // Reference record built from the even parity and stop bit rules.
    function automatic rxFrame expectedFrame(logic [7:0] data, logic parity, logic stopBit);
        rxFrame f;
        f.data       = {1'b0, data};
        f.isBreak    = (data == 8'h00) && !parity && !stopBit;
        f.parityErr  = !f.isBreak && (parity != ^data);
        f.framingErr = !f.isBreak && !stopBit;
        return f;
    endfunction

    task automatic driveLine(logic level, int cycles);
        rxLine = level;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendFrame(logic [7:0] data, logic flipParity, logic stopBit);
        logic parity;
        parity = (^data) ^ flipParity;
        modelQ.push_back(expectedFrame(data, parity, stopBit));  // Model leads the line.
        driveLine(1'b0, BitCycles);
        for (int i = 0; i < 8; i++) begin
            driveLine(data[i], BitCycles);                        // LSB first.
        end
        driveLine(parity, BitCycles);
        driveLine(stopBit, BitCycles);
    endtask

    task automatic checkFrame(rxFrame got, rxFrame exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %h/%b%b%b expected %h/%b%b%b (data/brk par frm)",
                     $time, what, got.data, got.isBreak, got.parityErr, got.framingErr,
                     exp.data, exp.isBreak, exp.parityErr, exp.framingErr);
        end
    endtask

    task automatic checkFlag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic readFrame(int maxCycles, string what);
        int     waited;
        rxFrame exp;
        waited = 0;
        while (!frameValid && waited < maxCycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!frameValid) begin
            errors++;
            $display("Timeout at %0t ns: no record for %s within %0d cycles",
                     $time, what, maxCycles);
        end else if (modelQ.size() == 0) begin
            errors++;
            $display("Unexpected record at %0t ns during %s", $time, what);
        end else begin
            exp = modelQ.pop_front();
            checkFrame(frameOut, exp, what);
            pop = 1'b1;
            @(posedge clk);
            #1;
            pop = 1'b0;
        end
    endtask

    task automatic finishTest(string name);
        $display("%-26s checks %0d, errors %0d", name, checks - testChecks, errors - testErrors);
        testChecks = checks;
        testErrors = errors;
    endtask

    initial begin
        logic [7:0] data;
        logic       seen;
        rst        = 1'b1;
        rxLine     = 1'b1;
        pop        = 1'b0;
        checks     = 0;
        errors     = 0;
        testChecks = 0;
        testErrors = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        driveLine(1'b1, 4);

        // Line side and host side run independently.
        fork
            begin
                for (int n = 0; n < 50; n++) begin
                    sendFrame(8'(takeBits(8)), 1'b0, 1'b1);
                    driveLine(1'b1, int'(takeBits(5) % 21));
                end
            end
            begin
                for (int n = 0; n < 50; n++) begin
                    readFrame(200, "random frame");
                end
            end
        join
        checkFlag(overflow, 1'b0, "overflow after random frames");
        finishTest("Test 1 random frames");

        for (int n = 0; n < 8; n++) begin
            sendFrame(8'(takeBits(8)), 1'b1, 1'b1);
            readFrame(2 * BitCycles, "parity error frame");
        end
        finishTest("Test 2 parity errors");

        for (int n = 0; n < 8; n++) begin
            data = 8'(takeBits(8));
            if (data == 8'h00) begin
                data = 8'h5a;
            end
            sendFrame(data, 1'b0, 1'b0);
            driveLine(1'b1, 2);
            readFrame(2 * BitCycles, "framing error frame");
            driveLine(1'b1, 2 * BitCycles);
        end
        finishTest("Test 3 framing errors");

        modelQ.push_back(expectedFrame(8'h00, 1'b0, 1'b0));
        driveLine(1'b0, 25 * BitCycles);                  // Longer than two whole frames.
        driveLine(1'b1, 3 * BitCycles);
        readFrame(2 * BitCycles, "break");
        checkFlag(frameValid, 1'b0, "single break record");
        sendFrame(8'(takeBits(8)), 1'b0, 1'b1);
        readFrame(2 * BitCycles, "frame after break");
        finishTest("Test 4 break");

        for (int n = 0; n < 6; n++) begin
            sendFrame(8'(takeBits(8)), 1'b0, 1'b1);
        end
        driveLine(1'b1, 2 * BitCycles);
        void'(modelQ.pop_back());                         // Last two hit a full queue.
        void'(modelQ.pop_back());
        checkFlag(overflow, 1'b1, "overflow after six frames");
        for (int n = 0; n < 4; n++) begin
            readFrame(2 * BitCycles, "queued frame");
        end
        checkFlag(frameValid, 1'b0, "queue empty after four reads");
        finishTest("Test 5 overflow");

        seen = 1'b0;
        driveLine(1'b0, 2);
        for (int n = 0; n < 2 * FrameBits * BitCycles; n++) begin
            seen = seen | frameValid;
            driveLine(1'b1, 1);
        end
        checkFlag(seen, 1'b0, "record after start glitch");
        sendFrame(8'(takeBits(8)), 1'b0, 1'b1);
        readFrame(2 * BitCycles, "frame after glitch");
        finishTest("Test 6 start glitch");

        if (modelQ.size() != 0) begin
            errors++;
            $display("The DUT never delivered %0d expected records", modelQ.size());
        end
        $display("Total checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
uartPkg.sv
rxControl.sv
bitTimer.sv
rxShiftReg.sv
frameCheck.sv
rxFifo.sv
uartRx.sv
tbUartRx.sv

// ==== Makefile ====
TOP = tbUartRx

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
